/* load_store_queue.sv */
`timescale 1ns/100ps
`default_nettype none

module load_store_queue (
    input  logic                                clk_i,
    input  logic                                rstn_i,
    input  logic                                flush_i,
    input  logic                                instr_valid_i,
    input  riscv_mem_pkg::mem_op_t              instr_op_i,
    input  logic [riscv_mem_pkg::XLEN-1:0]      instr_rs1_i,
    input  logic [riscv_mem_pkg::XLEN-1:0]      instr_imm_i,
    input  logic [riscv_mem_pkg::XLEN-1:0]      instr_data_i,
    input  logic [lsu_pkg::REG_ADDR_W-1:0]      instr_rd_i,
    input  logic [lsu_pkg::GL_INDEX_W-1:0]      instr_gl_index_i,
    input  logic                                read_next_i,      // Advance execute pointer
    input  logic                                advance_head_i,   // Retire head entry
    input  logic                                replay_i,         // Rewind execute pointer
    output logic                                head_valid_o,
    output riscv_mem_pkg::mem_op_t              head_op_o,
    output logic [riscv_mem_pkg::XLEN-1:0]      head_rs1_o,
    output logic [riscv_mem_pkg::XLEN-1:0]      head_imm_o,
    output logic [riscv_mem_pkg::XLEN-1:0]      head_data_o,
    output logic [lsu_pkg::REG_ADDR_W-1:0]      head_rd_o,
    output logic [lsu_pkg::GL_INDEX_W-1:0]      head_gl_index_o,
    output logic                                full_o,
    output logic                                empty_o
);

    riscv_mem_pkg::mem_op_t         op_mem   [lsu_pkg::LSQ_DEPTH];
    logic [riscv_mem_pkg::XLEN-1:0] rs1_mem  [lsu_pkg::LSQ_DEPTH];
    logic [riscv_mem_pkg::XLEN-1:0] imm_mem  [lsu_pkg::LSQ_DEPTH];
    logic [riscv_mem_pkg::XLEN-1:0] data_mem [lsu_pkg::LSQ_DEPTH];
    logic [lsu_pkg::REG_ADDR_W-1:0] rd_mem   [lsu_pkg::LSQ_DEPTH];
    logic [lsu_pkg::GL_INDEX_W-1:0] gl_mem   [lsu_pkg::LSQ_DEPTH];

    logic [lsu_pkg::LSQ_PTR_W-1:0]  head_q, tail_q, exec_q;
    logic [lsu_pkg::LSQ_PTR_W:0]    num_q;        // Entries from head to tail
    logic [lsu_pkg::LSQ_PTR_W:0]    num_exec_q;   // Entries from exec to tail
    logic                           wr_en;
    logic                           rd_en;

    assign wr_en = instr_valid_i & ~full_o;
    assign rd_en = read_next_i & head_valid_o;

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            head_q     <= '0;
            tail_q     <= '0;
            exec_q     <= '0;
            num_q      <= '0;
            num_exec_q <= '0;
        end else if (flush_i) begin
            head_q     <= '0;
            tail_q     <= '0;
            exec_q     <= '0;
            num_q      <= '0;
            num_exec_q <= '0;
        end else begin
            if (wr_en) tail_q <= tail_q + 1'b1;
            if (advance_head_i) head_q <= head_q + 1'b1;
            num_q <= num_q + {{lsu_pkg::LSQ_PTR_W{1'b0}}, wr_en}
                           - {{lsu_pkg::LSQ_PTR_W{1'b0}}, advance_head_i};
            if (replay_i) begin
                // Nack never coincides with a retire
                exec_q     <= head_q;
                num_exec_q <= num_q + {{lsu_pkg::LSQ_PTR_W{1'b0}}, wr_en};
            end else begin
                if (rd_en) exec_q <= exec_q + 1'b1;
                num_exec_q <= num_exec_q + {{lsu_pkg::LSQ_PTR_W{1'b0}}, wr_en}
                                         - {{lsu_pkg::LSQ_PTR_W{1'b0}}, rd_en};
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            op_mem[tail_q]   <= instr_op_i;
            rs1_mem[tail_q]  <= instr_rs1_i;
            imm_mem[tail_q]  <= instr_imm_i;
            data_mem[tail_q] <= instr_data_i;
            rd_mem[tail_q]   <= instr_rd_i;
            gl_mem[tail_q]   <= instr_gl_index_i;
        end
    end

    // Entry at the execute pointer
    assign head_valid_o    = (num_exec_q != '0);
    assign head_op_o       = op_mem[exec_q];
    assign head_rs1_o      = rs1_mem[exec_q];
    assign head_imm_o      = imm_mem[exec_q];
    assign head_data_o     = data_mem[exec_q];
    assign head_rd_o       = rd_mem[exec_q];
    assign head_gl_index_o = gl_mem[exec_q];

    assign full_o  = (num_q == lsu_pkg::LSQ_DEPTH);
    assign empty_o = (num_q == '0);

endmodule

`default_nettype wire

/* lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

    localparam int LSQ_DEPTH  = 8;   // Queue entries
    localparam int LSQ_PTR_W  = 3;   // log2 of LSQ_DEPTH
    localparam int GL_INDEX_W = 6;   // Graduation list index
    localparam int REG_ADDR_W = 5;   // Destination register

    // Issue automaton states
    typedef enum logic [1:0] {
        RESET_ST    = 2'b00,
        READ_HEAD   = 2'b01,
        WAIT_READY  = 2'b10,
        WAIT_COMMIT = 2'b11
    } issue_state_t;

endpackage

`default_nettype wire

/* mem_issue_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_issue_ctrl (
    input  logic                                clk_i,
    input  logic                                rstn_i,
    input  logic                                flush_i,
    input  logic                                head_valid_i,
    input  riscv_mem_pkg::mem_op_t              head_op_i,
    input  logic [riscv_mem_pkg::XLEN-1:0]      head_rs1_i,
    input  logic [riscv_mem_pkg::XLEN-1:0]      head_imm_i,
    input  logic [riscv_mem_pkg::XLEN-1:0]      head_data_i,
    input  logic [lsu_pkg::REG_ADDR_W-1:0]      head_rd_i,
    input  logic [lsu_pkg::GL_INDEX_W-1:0]      head_gl_index_i,
    input  logic                                dcache_ready_i,
    input  logic                                commit_store_i,   // Store at commit may write
    input  logic [riscv_mem_pkg::XLEN-1:0]      resp_addr_i,
    input  logic                                store_done_i,
    input  logic                                replay_i,
    output logic                                read_next_o,
    output logic                                req_valid_o,
    output riscv_mem_pkg::mem_op_t              req_op_o,
    output logic [riscv_mem_pkg::XLEN-1:0]      req_rs1_o,
    output logic [riscv_mem_pkg::XLEN-1:0]      req_imm_o,
    output logic [riscv_mem_pkg::XLEN-1:0]      req_data_o,
    output logic                                s1_valid_o,
    output riscv_mem_pkg::mem_op_t              s1_op_o,
    output logic [lsu_pkg::REG_ADDR_W-1:0]      s1_rd_o,
    output logic [lsu_pkg::GL_INDEX_W-1:0]      s1_gl_index_o,
    output logic [riscv_mem_pkg::XLEN-1:0]      s1_addr_o,
    output logic                                store_pending_o,
    output logic [lsu_pkg::GL_INDEX_W-1:0]      mem_gl_index_o,
    output logic                                commit_stall_o
);

    lsu_pkg::issue_state_t          state_q, state_d;

    // Copy of the entry taken from the queue
    riscv_mem_pkg::mem_op_t         held_op_q;
    logic [riscv_mem_pkg::XLEN-1:0] held_rs1_q, held_imm_q, held_data_q;
    logic [lsu_pkg::REG_ADDR_W-1:0] held_rd_q;
    logic [lsu_pkg::GL_INDEX_W-1:0] held_gl_q;

    riscv_mem_pkg::mem_op_t         sel_op;
    logic [riscv_mem_pkg::XLEN-1:0] sel_data;
    logic [lsu_pkg::REG_ADDR_W-1:0] sel_rd;
    logic [lsu_pkg::GL_INDEX_W-1:0] sel_gl;
    logic                           use_held;
    logic                           cand_valid, cand_store;
    logic                           other_store, store_ok, fire;

    logic [riscv_mem_pkg::XLEN-1:0] s1_data_q;
    logic                           store_on_fly_q;

    ////////////////////////////////////////
    // Candidate selection
    ////////////////////////////////////////

    assign use_held = (state_q != lsu_pkg::READ_HEAD);
    assign sel_op   = use_held ? held_op_q   : head_op_i;
    assign sel_data = use_held ? held_data_q : head_data_i;
    assign sel_rd   = use_held ? held_rd_q   : head_rd_i;
    assign sel_gl   = use_held ? held_gl_q   : head_gl_index_i;

    assign cand_valid = (state_q == lsu_pkg::READ_HEAD) ? head_valid_i
                                                        : (state_q != lsu_pkg::RESET_ST);
    assign cand_store = riscv_mem_pkg::is_store(sel_op);

    // A replayed store matches its own index
    assign other_store = store_on_fly_q & (mem_gl_index_o != sel_gl);
    assign store_ok    = ~cand_store | (commit_store_i & ~other_store);
    assign fire        = cand_valid & dcache_ready_i & store_ok;

    assign req_valid_o = fire & ~replay_i & ~flush_i;   // Squash on rewind
    assign req_op_o    = sel_op;
    assign req_rs1_o   = use_held ? held_rs1_q : head_rs1_i;
    assign req_imm_o   = use_held ? held_imm_q : head_imm_i;
    assign read_next_o = (state_q == lsu_pkg::READ_HEAD) & head_valid_i & ~replay_i & ~flush_i;

    ////////////////////////////////////////
    // Automaton
    ////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            lsu_pkg::RESET_ST: state_d = lsu_pkg::READ_HEAD;
            default: begin
                if (fire) begin
                    state_d = lsu_pkg::READ_HEAD;
                end else if (cand_valid) begin
                    // Cache free but the store lacks its commit
                    state_d = (dcache_ready_i & cand_store & ~other_store) ?
                              lsu_pkg::WAIT_COMMIT : lsu_pkg::WAIT_READY;
                end
            end
        endcase
    end

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= lsu_pkg::RESET_ST;
        end else if (flush_i || replay_i) begin
            state_q <= lsu_pkg::READ_HEAD;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (read_next_o) begin
            held_op_q   <= head_op_i;
            held_rs1_q  <= head_rs1_i;
            held_imm_q  <= head_imm_i;
            held_data_q <= head_data_i;
            held_rd_q   <= head_rd_i;
            held_gl_q   <= head_gl_index_i;
        end
    end

    ////////////////////////////////////////
    // Stage 1
    ////////////////////////////////////////

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            s1_valid_o <= 1'b0;
        end else begin
            s1_valid_o <= req_valid_o;   // Already low on flush or replay
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_valid_o) begin
            s1_op_o       <= sel_op;
            s1_rd_o       <= sel_rd;
            s1_gl_index_o <= sel_gl;
            s1_data_q     <= sel_data;
        end
        s1_addr_o <= resp_addr_i;   // Cache address, one cycle after the request
    end

    assign req_data_o = s1_data_q;  // Store data trails the request by a cycle

    // Store in flight, matched by commit through its index
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            store_on_fly_q <= 1'b0;
            mem_gl_index_o <= '0;
        end else if (flush_i) begin
            store_on_fly_q <= 1'b0;
            mem_gl_index_o <= '0;
        end else if (req_valid_o && cand_store) begin
            store_on_fly_q <= 1'b1;
            mem_gl_index_o <= sel_gl;
        end else if (store_done_i) begin
            store_on_fly_q <= 1'b0;
        end
    end

    assign store_pending_o = store_on_fly_q;
    assign commit_stall_o  = (cand_valid & cand_store & commit_store_i & ~other_store)
                           | (store_on_fly_q & ~store_done_i);

endmodule

`default_nettype wire

/* mem_resp_track.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_resp_track (
    input  logic                                clk_i,
    input  logic                                rstn_i,
    input  logic                                flush_i,
    input  logic                                s1_valid_i,
    input  riscv_mem_pkg::mem_op_t              s1_op_i,
    input  logic [lsu_pkg::REG_ADDR_W-1:0]      s1_rd_i,
    input  logic [lsu_pkg::GL_INDEX_W-1:0]      s1_gl_index_i,
    input  logic [riscv_mem_pkg::XLEN-1:0]      s1_addr_i,     // Latched, lines up with stage 2
    input  logic                                resp_valid_i,
    input  logic                                resp_nack_i,
    input  logic [riscv_mem_pkg::XLEN-1:0]      resp_data_i,
    input  logic                                resp_xcpt_ma_i,
    output logic                                advance_head_o,
    output logic                                replay_o,
    output logic                                store_done_o,
    output logic                                wb_valid_o,
    output logic [lsu_pkg::REG_ADDR_W-1:0]      wb_rd_o,
    output logic [lsu_pkg::GL_INDEX_W-1:0]      wb_gl_index_o,
    output logic [riscv_mem_pkg::XLEN-1:0]      wb_data_o,
    output logic                                wb_xcpt_valid_o,
    output riscv_mem_pkg::xcpt_cause_t          wb_xcpt_cause_o,
    output logic [riscv_mem_pkg::XLEN-1:0]      wb_xcpt_origin_o,
    output logic                                commit_xcpt_valid_o
);

    logic                           s2_valid_q;
    riscv_mem_pkg::mem_op_t         s2_op_q;
    logic [lsu_pkg::REG_ADDR_W-1:0] s2_rd_q;
    logic [lsu_pkg::GL_INDEX_W-1:0] s2_gl_q;

    logic s2_store;
    logic non_canon;
    logic xcpt;
    logic done;

    ////////////////////////////////////////
    // Stage 2
    ////////////////////////////////////////

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            s2_valid_q <= 1'b0;
        end else if (flush_i || replay_o) begin
            s2_valid_q <= 1'b0;   // Younger request is reissued
        end else begin
            s2_valid_q <= s1_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (s1_valid_i) begin
            s2_op_q <= s1_op_i;
            s2_rd_q <= s1_rd_i;
            s2_gl_q <= s1_gl_index_i;
        end
    end

    ////////////////////////////////////////
    // Response decision
    ////////////////////////////////////////

    assign s2_store = riscv_mem_pkg::is_store(s2_op_q);

    // Upper bits must copy the virtual address sign
    assign non_canon = s1_addr_i[riscv_mem_pkg::XLEN-1:riscv_mem_pkg::VA_BITS]
                    != {(riscv_mem_pkg::XLEN - riscv_mem_pkg::VA_BITS)
                        {s1_addr_i[riscv_mem_pkg::VA_BITS-1]}};
    assign xcpt = resp_xcpt_ma_i | non_canon;

    // Nack first, then exception, then completion
    assign replay_o       = s2_valid_q & resp_nack_i;
    assign done           = s2_valid_q & ~resp_nack_i & (xcpt | resp_valid_i);
    assign advance_head_o = done;
    assign store_done_o   = done & s2_store;

    always_comb begin
        if (resp_xcpt_ma_i) begin
            wb_xcpt_cause_o = s2_store ? riscv_mem_pkg::ST_ADDR_MISALIGNED
                                       : riscv_mem_pkg::LD_ADDR_MISALIGNED;
        end else begin
            wb_xcpt_cause_o = s2_store ? riscv_mem_pkg::ST_ACCESS_FAULT
                                       : riscv_mem_pkg::LD_ACCESS_FAULT;
        end
    end

    // Load writeback in the response cycle
    assign wb_valid_o       = done & ~s2_store;
    assign wb_rd_o          = s2_rd_q;
    assign wb_gl_index_o    = s2_gl_q;
    assign wb_data_o        = xcpt ? '0 : resp_data_i;
    assign wb_xcpt_valid_o  = wb_valid_o & xcpt;
    assign wb_xcpt_origin_o = s1_addr_i;

    assign commit_xcpt_valid_o = store_done_o & xcpt;   // Faulting store goes to commit

endmodule

`default_nettype wire

/* mem_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_unit (
    input  logic                                clk_i,
    input  logic                                rstn_i,
    input  logic                                flush_i,
    input  logic                                instr_valid_i,
    input  riscv_mem_pkg::mem_op_t              instr_op_i,
    input  logic [riscv_mem_pkg::XLEN-1:0]      instr_rs1_i,
    input  logic [riscv_mem_pkg::XLEN-1:0]      instr_imm_i,
    input  logic [riscv_mem_pkg::XLEN-1:0]      instr_data_i,
    input  logic [lsu_pkg::REG_ADDR_W-1:0]      instr_rd_i,
    input  logic [lsu_pkg::GL_INDEX_W-1:0]      instr_gl_index_i,
    input  logic                                commit_store_i,
    output logic                                req_valid_o,
    output riscv_mem_pkg::mem_op_t              req_op_o,
    output logic [riscv_mem_pkg::XLEN-1:0]      req_rs1_o,
    output logic [riscv_mem_pkg::XLEN-1:0]      req_imm_o,
    output logic [riscv_mem_pkg::XLEN-1:0]      req_data_o,
    input  logic                                dcache_ready_i,
    input  logic                                resp_valid_i,
    input  logic                                resp_nack_i,
    input  logic [riscv_mem_pkg::XLEN-1:0]      resp_data_i,
    input  logic [riscv_mem_pkg::XLEN-1:0]      resp_addr_i,
    input  logic                                resp_xcpt_ma_i,
    output logic                                wb_valid_o,
    output logic [lsu_pkg::REG_ADDR_W-1:0]      wb_rd_o,
    output logic [lsu_pkg::GL_INDEX_W-1:0]      wb_gl_index_o,
    output logic [riscv_mem_pkg::XLEN-1:0]      wb_data_o,
    output logic                                wb_xcpt_valid_o,
    output riscv_mem_pkg::xcpt_cause_t          wb_xcpt_cause_o,
    output logic [riscv_mem_pkg::XLEN-1:0]      wb_xcpt_origin_o,
    output logic                                commit_xcpt_valid_o,
    output logic                                lock_o,
    output logic                                empty_o,
    output logic                                store_pending_o,
    output logic [lsu_pkg::GL_INDEX_W-1:0]      mem_gl_index_o,
    output logic                                commit_stall_o
);

    logic                           head_valid;
    riscv_mem_pkg::mem_op_t         head_op;
    logic [riscv_mem_pkg::XLEN-1:0] head_rs1, head_imm, head_data;
    logic [lsu_pkg::REG_ADDR_W-1:0] head_rd;
    logic [lsu_pkg::GL_INDEX_W-1:0] head_gl_index;
    logic                           read_next, advance_head, replay, store_done;

    logic                           s1_valid;
    riscv_mem_pkg::mem_op_t         s1_op;
    logic [lsu_pkg::REG_ADDR_W-1:0] s1_rd;
    logic [lsu_pkg::GL_INDEX_W-1:0] s1_gl_index;
    logic [riscv_mem_pkg::XLEN-1:0] s1_addr;

    load_store_queue u_lsq (
        .clk_i(clk_i), .rstn_i(rstn_i), .flush_i(flush_i),
        .instr_valid_i(instr_valid_i), .instr_op_i(instr_op_i),
        .instr_rs1_i(instr_rs1_i), .instr_imm_i(instr_imm_i),
        .instr_data_i(instr_data_i), .instr_rd_i(instr_rd_i),
        .instr_gl_index_i(instr_gl_index_i),
        .read_next_i(read_next), .advance_head_i(advance_head), .replay_i(replay),
        .head_valid_o(head_valid), .head_op_o(head_op), .head_rs1_o(head_rs1),
        .head_imm_o(head_imm), .head_data_o(head_data), .head_rd_o(head_rd),
        .head_gl_index_o(head_gl_index),
        .full_o(lock_o), .empty_o(empty_o)
    );

    mem_issue_ctrl u_issue (
        .clk_i(clk_i), .rstn_i(rstn_i), .flush_i(flush_i),
        .head_valid_i(head_valid), .head_op_i(head_op), .head_rs1_i(head_rs1),
        .head_imm_i(head_imm), .head_data_i(head_data), .head_rd_i(head_rd),
        .head_gl_index_i(head_gl_index),
        .dcache_ready_i(dcache_ready_i), .commit_store_i(commit_store_i),
        .resp_addr_i(resp_addr_i), .store_done_i(store_done), .replay_i(replay),
        .read_next_o(read_next), .req_valid_o(req_valid_o), .req_op_o(req_op_o),
        .req_rs1_o(req_rs1_o), .req_imm_o(req_imm_o), .req_data_o(req_data_o),
        .s1_valid_o(s1_valid), .s1_op_o(s1_op), .s1_rd_o(s1_rd),
        .s1_gl_index_o(s1_gl_index), .s1_addr_o(s1_addr),
        .store_pending_o(store_pending_o), .mem_gl_index_o(mem_gl_index_o),
        .commit_stall_o(commit_stall_o)
    );

    mem_resp_track u_resp (
        .clk_i(clk_i), .rstn_i(rstn_i), .flush_i(flush_i),
        .s1_valid_i(s1_valid), .s1_op_i(s1_op), .s1_rd_i(s1_rd),
        .s1_gl_index_i(s1_gl_index), .s1_addr_i(s1_addr),
        .resp_valid_i(resp_valid_i), .resp_nack_i(resp_nack_i),
        .resp_data_i(resp_data_i), .resp_xcpt_ma_i(resp_xcpt_ma_i),
        .advance_head_o(advance_head), .replay_o(replay), .store_done_o(store_done),
        .wb_valid_o(wb_valid_o), .wb_rd_o(wb_rd_o), .wb_gl_index_o(wb_gl_index_o),
        .wb_data_o(wb_data_o), .wb_xcpt_valid_o(wb_xcpt_valid_o),
        .wb_xcpt_cause_o(wb_xcpt_cause_o), .wb_xcpt_origin_o(wb_xcpt_origin_o),
        .commit_xcpt_valid_o(commit_xcpt_valid_o)
    );

endmodule

`default_nettype wire

/* riscv_mem_pkg.sv */
`default_nettype none

package riscv_mem_pkg;

    localparam int XLEN    = 64;   // Data and address width
    localparam int VA_BITS = 40;   // Virtual address width, bit 39 is the sign

    // Scalar memory operations
    typedef enum logic [3:0] {
        LD  = 4'd0,
        LW  = 4'd1,
        LWU = 4'd2,
        LH  = 4'd3,
        LHU = 4'd4,
        LB  = 4'd5,
        LBU = 4'd6,
        SD  = 4'd7,
        SW  = 4'd8,
        SH  = 4'd9,
        SB  = 4'd10
    } mem_op_t;

    // Exception causes raised by the memory unit
    typedef enum logic [3:0] {
        LD_ADDR_MISALIGNED = 4'd4,
        LD_ACCESS_FAULT    = 4'd5,
        ST_ADDR_MISALIGNED = 4'd6,
        ST_ACCESS_FAULT    = 4'd7
    } xcpt_cause_t;

    function automatic logic is_store(input mem_op_t op);
        return op inside {SD, SW, SH, SB};
    endfunction

endpackage

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module tb_mem_unit -o sim_tb
./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "Regression failed" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
if ! grep -q "Regression passed" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi

/* tb_mem_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_mem_unit;

    localparam int NUM_INSTR   = 60;
    localparam int NUM_FILL    = lsu_pkg::LSQ_DEPTH;
    localparam int TEST_CYCLES = 16 + NUM_INSTR * 10 + 40;
    localparam int CYCLE_LIMIT = 10 * TEST_CYCLES;
    localparam logic [63:0] DATA_KEY = 64'h5a5a_0f0f_c3c3_9696;

    logic                           clk_i, rstn_i, flush_i, instr_valid_i, commit_store_i;
    riscv_mem_pkg::mem_op_t         instr_op_i, req_op_o;
    logic [63:0]                    instr_rs1_i, instr_imm_i, instr_data_i;
    logic [lsu_pkg::REG_ADDR_W-1:0] instr_rd_i, wb_rd_o;
    logic [lsu_pkg::GL_INDEX_W-1:0] instr_gl_index_i, wb_gl_index_o, mem_gl_index_o;
    logic                           req_valid_o, dcache_ready_i, resp_valid_i, resp_nack_i;
    logic [63:0]                    req_rs1_o, req_imm_o, req_data_o, resp_data_i, resp_addr_i;
    logic                           resp_xcpt_ma_i, wb_valid_o, wb_xcpt_valid_o;
    logic [63:0]                    wb_data_o, wb_xcpt_origin_o;
    riscv_mem_pkg::xcpt_cause_t     wb_xcpt_cause_o;
    logic                           commit_xcpt_valid_o, lock_o, empty_o;
    logic                           store_pending_o, commit_stall_o;

    mem_unit u_dut (.*);

    // Program and expected results
    logic [3:0]  g_op   [NUM_INSTR + NUM_FILL];
    logic [63:0] g_rs1  [NUM_INSTR + NUM_FILL];
    logic [63:0] g_imm  [NUM_INSTR + NUM_FILL];
    logic [63:0] g_data [NUM_INSTR + NUM_FILL];
    logic [4:0]  g_rd   [NUM_INSTR + NUM_FILL];
    logic [4:0]  exp_rd [$];
    logic [5:0]  exp_gl [$];
    logic [63:0] exp_addr [$];
    logic        exp_fault [$];
    logic [3:0]  exp_cause [$];
    logic [63:0] st_addr [$];    // Faulting stores in program order
    logic [3:0]  st_cause [$];
    int          gen_idx, gen_limit, cycle_cnt;
    logic        hold_ready, enq_always, pend_chk;
    logic [5:0]  pend_gl;
    logic [63:0] pend_data;
    logic        nacked [64];
    logic [15:0] lfsr;

    // Cache model pipeline through stages 1 and 2
    logic        nr_valid, nr_nack, nr_ma, p1_valid, p1_nack, p1_ma, p2_valid, p2_nack, p2_ma;
    logic [63:0] nr_addr, p1_addr, p2_addr;

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: run exceeded %0d cycles", CYCLE_LIMIT);
            $display("Regression failed");
            $fatal(1);
        end
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    function automatic logic lfsr_bit();
        logic fb;
        fb   = lfsr[15] ^ lfsr[14] ^ lfsr[12] ^ lfsr[3];   // x^16+x^15+x^13+x^4+1
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) v = {v[62:0], lfsr_bit()};
        return v;
    endfunction

    function automatic logic writes_mem(input logic [3:0] op);
        return op >= 4'd7;   // SD, SW, SH, SB
    endfunction

    function automatic logic misaligned(input logic [63:0] addr, input logic [3:0] op);
        logic [3:0] bytes;
        case (op)
            4'd0, 4'd7:       bytes = 4'd8;
            4'd1, 4'd2, 4'd8: bytes = 4'd4;
            4'd3, 4'd4, 4'd9: bytes = 4'd2;
            default:          bytes = 4'd1;
        endcase
        return (addr[3:0] & (bytes - 4'd1)) != 4'd0;
    endfunction

    task automatic value_fail(input string name, input logic [63:0] got, input logic [63:0] exp);
        $display("FAIL at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic rule_fail(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic gen_program();
        logic [63:0] base, kind;
        for (int i = 0; i < NUM_INSTR + NUM_FILL; i++) begin
            g_op[i] = 4'(rand_bits(4) % 11);
            kind    = rand_bits(3);
            base    = rand_bits(24) << 3;
            if (kind == 0) base = base + 64'd1;            // Misaligned unless byte wide
            if (kind == 1) base = base | (64'd1 << 50);    // Not canonical
            g_rs1[i]  = base;
            g_imm[i]  = {55'd0, 6'(i), 3'd0};              // Index recoverable from imm
            g_data[i] = rand_bits(32);
            g_rd[i]   = 5'(rand_bits(5));
        end
    endtask

    task automatic push_expected(input int i);
        logic [63:0] addr;
        logic        ma, nc;
        addr = g_rs1[i] + g_imm[i];
        ma   = misaligned(addr, g_op[i]);
        nc   = addr[63:40] != {24{addr[39]}};
        if (writes_mem(g_op[i])) begin
            if (ma || nc) begin
                st_addr.push_back(addr);
                st_cause.push_back(ma ? 4'd6 : 4'd7);
            end
        end else begin
            exp_rd.push_back(g_rd[i]);
            exp_gl.push_back(6'(i));
            exp_addr.push_back(addr);
            exp_fault.push_back(ma | nc);
            exp_cause.push_back(ma ? 4'd4 : 4'd5);
        end
    endtask

    ////////////////////////////////////////
    // One clock cycle
    ////////////////////////////////////////

    task automatic step();
        logic [63:0] addr;
        logic [5:0]  gl;
        @(negedge clk_i);
        {p2_valid, p2_nack, p2_ma, p2_addr} = {p1_valid, p1_nack, p1_ma, p1_addr};
        {p1_valid, p1_nack, p1_ma, p1_addr} = {nr_valid, nr_nack, nr_ma, nr_addr};
        nr_valid       = 1'b0;
        resp_addr_i    = p1_addr;
        resp_valid_i   = p2_valid & ~p2_nack;
        resp_nack_i    = p2_valid & p2_nack;
        resp_xcpt_ma_i = p2_valid & p2_ma;
        resp_data_i    = p2_addr ^ DATA_KEY;
        dcache_ready_i = hold_ready ? 1'b0 : (rand_bits(2) != 0);
        commit_store_i = lfsr_bit();
        instr_valid_i  = 1'b0;
        if (gen_idx < gen_limit && !lock_o && (enq_always || rand_bits(2) != 0)) begin
            instr_valid_i    = 1'b1;
            instr_op_i       = riscv_mem_pkg::mem_op_t'(g_op[gen_idx]);
            instr_rs1_i      = g_rs1[gen_idx];
            instr_imm_i      = g_imm[gen_idx];
            instr_data_i     = g_data[gen_idx];
            instr_rd_i       = g_rd[gen_idx];
            instr_gl_index_i = 6'(gen_idx);
            if (gen_idx < NUM_INSTR) push_expected(gen_idx);
            gen_idx++;
        end
        #10;
        if (!dcache_ready_i) assert (!req_valid_o) else value_fail("req_valid_o", 1, 0);
        if (pend_chk) begin
            assert (store_pending_o) else value_fail("store_pending_o", 0, 1);
            assert (mem_gl_index_o == pend_gl)
                else value_fail("mem_gl_index_o", 64'(mem_gl_index_o), 64'(pend_gl));
            assert (req_data_o == pend_data)
                else value_fail("req_data_o", req_data_o, pend_data);
            assert (commit_stall_o) else value_fail("commit_stall_o", 0, 1);
            pend_chk = 1'b0;
        end
        if (req_valid_o) begin
            addr     = req_rs1_o + req_imm_o;
            gl       = req_imm_o[8:3];
            assert (req_op_o == g_op[gl])
                else value_fail("req_op_o", 64'(req_op_o), 64'(g_op[gl]));
            nr_valid = 1'b1;
            nr_addr  = addr;
            nr_ma    = misaligned(addr, req_op_o);
            nr_nack  = !nacked[gl] && rand_bits(3) == 0;   // Each index nacked at most once
            if (nr_nack) nacked[gl] = 1'b1;
            if (writes_mem(req_op_o)) begin
                assert (commit_store_i) else rule_fail("store issued without commit_store_i");
                pend_chk  = 1'b1;
                pend_gl   = gl;
                pend_data = g_data[gl];
            end
        end
        if (wb_valid_o) begin
            assert (exp_rd.size() != 0) else rule_fail("writeback with no load outstanding");
            assert (wb_rd_o == exp_rd[0])
                else value_fail("wb_rd_o", 64'(wb_rd_o), 64'(exp_rd[0]));
            assert (wb_gl_index_o == exp_gl[0])
                else value_fail("wb_gl_index_o", 64'(wb_gl_index_o), 64'(exp_gl[0]));
            assert (wb_xcpt_valid_o == exp_fault[0])
                else value_fail("wb_xcpt_valid_o", 64'(wb_xcpt_valid_o), 64'(exp_fault[0]));
            if (exp_fault[0]) begin
                assert (wb_xcpt_cause_o == exp_cause[0])
                    else value_fail("wb_xcpt_cause_o", 64'(wb_xcpt_cause_o), 64'(exp_cause[0]));
                assert (wb_xcpt_origin_o == exp_addr[0])
                    else value_fail("wb_xcpt_origin_o", wb_xcpt_origin_o, exp_addr[0]);
            end else begin
                assert (wb_data_o == (exp_addr[0] ^ DATA_KEY))
                    else value_fail("wb_data_o", wb_data_o, exp_addr[0] ^ DATA_KEY);
            end
            void'(exp_rd.pop_front());
            void'(exp_gl.pop_front());
            void'(exp_addr.pop_front());
            void'(exp_fault.pop_front());
            void'(exp_cause.pop_front());
        end
        if (commit_xcpt_valid_o) begin
            assert (st_cause.size() != 0) else rule_fail("unexpected store exception");
            assert (wb_xcpt_cause_o == st_cause[0])
                else value_fail("wb_xcpt_cause_o", 64'(wb_xcpt_cause_o), 64'(st_cause[0]));
            assert (wb_xcpt_origin_o == st_addr[0])
                else value_fail("wb_xcpt_origin_o", wb_xcpt_origin_o, st_addr[0]);
            void'(st_cause.pop_front());
            void'(st_addr.pop_front());
        end
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        lfsr = 16'd29;
        {rstn_i, flush_i, instr_valid_i, commit_store_i, dcache_ready_i} = '0;
        {resp_valid_i, resp_nack_i, resp_xcpt_ma_i} = '0;
        {instr_rs1_i, instr_imm_i, instr_data_i, resp_data_i, resp_addr_i} = '0;
        instr_op_i       = riscv_mem_pkg::LD;
        instr_rd_i       = '0;
        instr_gl_index_i = '0;
        {nr_valid, nr_nack, nr_ma, p1_valid, p1_nack, p1_ma} = '0;
        {p2_valid, p2_nack, p2_ma, hold_ready, enq_always, pend_chk} = '0;
        {nr_addr, p1_addr, p2_addr} = '0;
        pend_gl   = '0;
        pend_data = '0;
        {gen_idx, cycle_cnt} = '0;
        for (int i = 0; i < 64; i++) nacked[i] = 1'b0;
        gen_program();

        repeat (16) @(negedge clk_i);
        rstn_i = 1'b1;
        #10;
        assert (empty_o) else value_fail("empty_o", 64'(empty_o), 1);
        assert (!req_valid_o) else value_fail("req_valid_o", 64'(req_valid_o), 0);
        assert (!wb_valid_o) else value_fail("wb_valid_o", 64'(wb_valid_o), 0);
        assert (!commit_stall_o) else value_fail("commit_stall_o", 64'(commit_stall_o), 0);
        assert (!lock_o) else value_fail("lock_o", 64'(lock_o), 0);

        // Mixed traffic with back-pressure, nacks and faults
        gen_limit = NUM_INSTR;
        while (gen_idx < gen_limit || exp_rd.size() != 0 || !empty_o || store_pending_o) step();
        assert (st_cause.size() == 0) else rule_fail("faulting store retired without exception");

        // Fill with the cache stalled and flush
        hold_ready = 1'b1;
        enq_always = 1'b1;
        gen_limit  = NUM_INSTR + NUM_FILL;
        while (gen_idx < gen_limit) step();
        step();
        assert (lock_o) else value_fail("lock_o", 64'(lock_o), 1);
        @(negedge clk_i);
        flush_i = 1'b1;
        @(negedge clk_i);
        flush_i    = 1'b0;
        hold_ready = 1'b0;
        #10;
        assert (empty_o) else value_fail("empty_o", 64'(empty_o), 1);
        repeat (12) step();   // Any writeback here fails in step
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
riscv_mem_pkg.sv
lsu_pkg.sv
load_store_queue.sv
mem_issue_ctrl.sv
mem_resp_track.sv
mem_unit.sv
tb_mem_unit.sv
